// ==== verilog/btb_config_pkg.sv ====
`default_nettype none

package btb_config_pkg;

	parameter int BTB_ROWS    = 8;                    // Rows in the buffer
	parameter int ROW_BITS    = (BTB_ROWS > 1) ? $clog2(BTB_ROWS) : 1; // Row index width
	parameter int TAG_BITS    = 10;                   // Tag is PC[11:2]
	parameter int TARGET_BITS = 12;                   // Stored target is target[13:2]
	parameter int PC_BITS     = 32;                   // Full PC width

	// Fetch and branch PCs are word aligned, so bits 1:0 are never stored
	parameter int WORD_LSB    = 2;

endpackage

`default_nettype wire

// ==== verilog/btb_types_pkg.sv ====
`default_nettype none

package btb_types_pkg;

	import btb_config_pkg::*;

	typedef struct packed {
		logic [PC_BITS-1:0]     pc;           // Current fetch PC
	} btb_fetch_t;

	typedef struct packed {
		logic                   valid_target; // Target below is usable
		logic [PC_BITS-1:0]     target_pc;    // Rebuilt predicted target
	} btb_predict_t;

	typedef struct packed {
		logic                   valid;        // Resolve strobe from execute
		logic                   taken;        // Branch was taken
		logic [PC_BITS-1:0]     pc;           // Branch PC
		logic [PC_BITS-1:0]     target;       // Calculated target
	} btb_resolve_t;

	typedef struct packed {
		logic                   valid;        // Row holds an entry
		logic [TAG_BITS-1:0]    tag;          // PC tag field
		logic [TARGET_BITS-1:0] target;       // Partial target
	} btb_row_t;

	typedef struct packed {
		logic                   enable;       // Write this cycle
		logic [ROW_BITS-1:0]    row;          // Row to write
		btb_row_t               data;         // New row contents
	} btb_write_t;

endpackage

`default_nettype wire

// ==== verilog/btb_row_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_row_counter #(
	parameter int ROWS = 8,
	localparam int IDX_BITS = (ROWS > 1) ? $clog2(ROWS) : 1
) (
	input  wire                 clock,
	input  wire                 reset,
	input  logic                clear,    // Back to row 0
	input  logic                advance,  // Step one row
	output logic [IDX_BITS-1:0] count,
	output logic                wrap      // At last row
);

	localparam logic [IDX_BITS-1:0] LAST = IDX_BITS'(ROWS - 1);

	assign wrap = (count == LAST);        // Last row of the sweep or rotation

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin          // Clear wins over advance
			count <= '0;
		end else if (advance) begin
			if (wrap) begin
				count <= '0;                   // Modulo ROWS, not modulo 2**IDX_BITS
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/btb_sweep_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_sweep_fsm import btb_types_pkg::*; #(
	parameter int ROWS        = 8,
	parameter int TAG_BITS    = 10,
	parameter int TARGET_BITS = 12,
	localparam int IDX_BITS   = (ROWS > 1) ? $clog2(ROWS) : 1
) (
	input  wire                 clock,
	input  wire                 reset,
	input  wire                 flush,          // One cycle flush pulse
	input  btb_resolve_t        resolve,
	input  logic                resolve_hit,    // Branch PC found in a row
	input  logic [IDX_BITS-1:0] resolve_row,    // Row holding the branch PC
	input  logic [IDX_BITS-1:0] sweep_row,      // Row being cleared
	input  logic                sweep_wrap,     // Last row of the sweep
	input  logic [IDX_BITS-1:0] victim_row,     // Round robin insert row
	output logic                sweep_clear,
	output logic                sweep_advance,
	output logic                victim_advance, // Pulse on each insert
	output btb_write_t          write,
	output logic                ready
);

	typedef enum logic {
		SWEEP,                                  // Clearing valid bits
		READY                                   // Serving lookups and resolves
	} state_t;

	state_t state;
	state_t state_next;

	logic [TAG_BITS-1:0]    resolve_tag;
	logic [TARGET_BITS-1:0] resolve_target;

	assign resolve_tag    = resolve.pc[TAG_BITS+1:2];        // PC[11:2] by default
	assign resolve_target = resolve.target[TARGET_BITS+1:2]; // Target[13:2] by default

	assign ready = (state == READY);

	always_comb begin
		state_next     = state;
		sweep_clear    = flush;                 // Any flush restarts the sweep at row 0
		sweep_advance  = 1'b0;
		victim_advance = 1'b0;
		write          = '0;
		case (state)
			SWEEP: begin
				write.enable  = 1'b1;               // Invalidate one row per cycle
				write.row     = sweep_row;
				sweep_advance = 1'b1;
				if (!flush && sweep_wrap) begin
					state_next = READY;
				end
			end
			READY: begin
				if (resolve.valid && resolve.taken) begin
					write.enable      = 1'b1;
					write.data.valid  = 1'b1;
					write.data.tag    = resolve_tag;
					write.data.target = resolve_target;
					if (resolve_hit) begin
						write.row = resolve_row;        // Rewrite target in place
					end else begin
						write.row      = victim_row;    // Insert over the victim
						victim_advance = 1'b1;
					end
				end else if (resolve.valid && resolve_hit) begin
					write.enable = 1'b1;              // Not taken hit drops the row
					write.row    = resolve_row;
				end
				if (flush) begin
					state_next = SWEEP;               // Sweep starts next cycle
				end
			end
			default: state_next = SWEEP;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SWEEP;
		end else begin
			state <= state_next;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/btb_tag_match.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_tag_match import btb_types_pkg::*; #(
	parameter int ROWS      = 8,
	parameter int TAG_BITS  = 10,
	localparam int IDX_BITS = (ROWS > 1) ? $clog2(ROWS) : 1
) (
	input  btb_row_t [ROWS-1:0] rows,     // All rows from storage
	input  logic [TAG_BITS-1:0] tag,      // Tag to look for
	output logic                hit,
	output logic [IDX_BITS-1:0] hit_row   // Lowest matching row
);

	logic [ROWS-1:0] match;               // One compare per row

	always_comb begin
		for (int i = 0; i < ROWS; i++) begin
			match[i] = rows[i].valid && (rows[i].tag == tag);
		end
	end

	assign hit = |match;

	// Priority encode from the top down so the lowest row wins
	always_comb begin
		hit_row = '0;
		for (int i = ROWS - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_row = IDX_BITS'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/btb_storage.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_storage import btb_types_pkg::*; #(
	parameter int ROWS        = 8,
	parameter int TAG_BITS    = 10,
	parameter int TARGET_BITS = 12
) (
	input  wire                 clock,
	input  btb_write_t          write,     // Single write port
	output btb_row_t [ROWS-1:0] rows       // Every row, read in parallel
);

	logic [ROWS-1:0]        valid_q;       // Cleared by the sweep, not by reset
	logic [TAG_BITS-1:0]    tag_q [ROWS];
	logic [TARGET_BITS-1:0] target_q [ROWS];

	always_ff @(posedge clock) begin
		if (write.enable) begin
			valid_q[write.row]  <= write.data.valid;
			tag_q[write.row]    <= write.data.tag;
			target_q[write.row] <= write.data.target;
		end
	end

	always_comb begin
		for (int i = 0; i < ROWS; i++) begin
			rows[i].valid  = valid_q[i];
			rows[i].tag    = tag_q[i];
			rows[i].target = target_q[i];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/btb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_top import btb_config_pkg::*; import btb_types_pkg::*; #(
	parameter int BTB_ROWS    = btb_config_pkg::BTB_ROWS,
	parameter int TAG_BITS    = btb_config_pkg::TAG_BITS,
	parameter int TARGET_BITS = btb_config_pkg::TARGET_BITS,
	localparam int IDX_BITS   = (BTB_ROWS > 1) ? $clog2(BTB_ROWS) : 1
) (
	input  wire          clock,
	input  wire          reset,
	input  btb_fetch_t   fetch,
	input  btb_resolve_t resolve,
	input  wire          flush,      // One cycle pulse, starts a sweep
	output btb_predict_t predict,
	output logic         ready       // Low while sweeping
);

	btb_row_t [BTB_ROWS-1:0] rows;
	btb_write_t              write;

	logic [TAG_BITS-1:0] fetch_tag;
	logic [TAG_BITS-1:0] resolve_tag;
	logic                fetch_hit;
	logic [IDX_BITS-1:0] fetch_row;
	logic                resolve_hit;
	logic [IDX_BITS-1:0] resolve_row;
	logic [IDX_BITS-1:0] sweep_row;
	logic                sweep_wrap;
	logic                sweep_clear;
	logic                sweep_advance;
	logic [IDX_BITS-1:0] victim_row;
	logic                victim_advance;

	assign fetch_tag   = fetch.pc[TAG_BITS+1:2];
	assign resolve_tag = resolve.pc[TAG_BITS+1:2];

	btb_row_counter #(.ROWS(BTB_ROWS)) sweep_ctr (
		.clock(clock), .reset(reset),
		.clear(sweep_clear), .advance(sweep_advance),
		.count(sweep_row), .wrap(sweep_wrap)
	);

	btb_row_counter #(.ROWS(BTB_ROWS)) victim_ctr ( // Survives flush
		.clock(clock), .reset(reset),
		.clear(1'b0), .advance(victim_advance),
		.count(victim_row), .wrap()
	);

	btb_sweep_fsm #(.ROWS(BTB_ROWS), .TAG_BITS(TAG_BITS), .TARGET_BITS(TARGET_BITS)) sweep_fsm (
		.clock(clock), .reset(reset), .flush(flush), .resolve(resolve),
		.resolve_hit(resolve_hit), .resolve_row(resolve_row),
		.sweep_row(sweep_row), .sweep_wrap(sweep_wrap), .victim_row(victim_row),
		.sweep_clear(sweep_clear), .sweep_advance(sweep_advance),
		.victim_advance(victim_advance), .write(write), .ready(ready)
	);

	btb_storage #(.ROWS(BTB_ROWS), .TAG_BITS(TAG_BITS), .TARGET_BITS(TARGET_BITS)) storage (
		.clock(clock), .write(write), .rows(rows)
	);

	btb_tag_match #(.ROWS(BTB_ROWS), .TAG_BITS(TAG_BITS)) fetch_match (
		.rows(rows), .tag(fetch_tag), .hit(fetch_hit), .hit_row(fetch_row)
	);

	btb_tag_match #(.ROWS(BTB_ROWS), .TAG_BITS(TAG_BITS)) resolve_match (
		.rows(rows), .tag(resolve_tag), .hit(resolve_hit), .hit_row(resolve_row)
	);

	// Upper target bits come from the fetch PC, the low word bits are zero
	assign predict.valid_target = fetch_hit && ready;  // Rows are stale while sweeping
	assign predict.target_pc    = {fetch.pc[PC_BITS-1:TARGET_BITS+2],
	                               rows[fetch_row].target, 2'b00};

endmodule

`default_nettype wire

// ==== tests/btb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;     // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);   // Four cycles of reset
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/btb_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_assertions import btb_types_pkg::*; #(
	parameter int ROWS = 8
) (
	input wire          clock,
	input wire          reset,
	input btb_fetch_t   fetch,
	input btb_resolve_t resolve,
	input btb_predict_t predict,
	input logic         ready
);

	int low_cycles;                            // Length of the current ready low stretch

	always_ff @(posedge clock) begin
		if (reset || ready) begin
			low_cycles <= 0;
		end else begin
			low_cycles <= low_cycles + 1;
		end
	end

	// No prediction while the rows are being swept
	no_predict_when_busy: assert property (@(posedge clock) disable iff (reset)
		!ready |-> !predict.valid_target)
		else $error("prediction valid while ready is low");

	// A resolve seen while busy must not create a hit
	resolve_dropped_when_busy: assert property (@(posedge clock) disable iff (reset)
		($past(!ready && resolve.valid && !predict.valid_target) && fetch == $past(fetch))
		|-> !predict.valid_target)
		else $error("resolve took effect while ready was low");

	sweep_length: assert property (@(posedge clock) disable iff (reset)
		$rose(ready) |-> low_cycles == ROWS)
		else $error("ready rose after the wrong number of sweep cycles");

endmodule

bind btb_top btb_assertions #(.ROWS(BTB_ROWS)) assertions_i (
	.clock(clock), .reset(reset), .fetch(fetch), .resolve(resolve),
	.predict(predict), .ready(ready)
);

`default_nettype wire

// ==== tests/btb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_tb import btb_config_pkg::*; import btb_types_pkg::*; ();

	logic         clock;
	logic         reset;
	btb_fetch_t   fetch;
	btb_resolve_t resolve;
	logic         flush;
	btb_predict_t predict;
	logic         ready;

	logic                   m_valid [BTB_ROWS];   // Reference rows
	logic [TAG_BITS-1:0]    m_tag [BTB_ROWS];
	logic [TARGET_BITS-1:0] m_target [BTB_ROWS];
	int                     m_victim;             // Reference round robin pointer
	logic [PC_BITS-1:0]     known [$];            // PCs seen so far
	int                     seed = 83;

	btb_clock_gen clock_gen (.clock(clock), .reset(reset));

	btb_top #(.BTB_ROWS(BTB_ROWS), .TAG_BITS(TAG_BITS), .TARGET_BITS(TARGET_BITS)) btb_top_i (
		.clock(clock), .reset(reset), .fetch(fetch), .resolve(resolve),
		.flush(flush), .predict(predict), .ready(ready)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_predict(input btb_predict_t got, input btb_predict_t exp);
		if (got.valid_target !== exp.valid_target) begin
			stop_run($sformatf("ERR predict.valid_target got %h exp %h",
				got.valid_target, exp.valid_target));
		end else if (exp.valid_target && got.target_pc !== exp.target_pc) begin
			stop_run($sformatf("ERR predict.target_pc got %h exp %h",
				got.target_pc, exp.target_pc));
		end
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("ERR ready got %h exp %h", got, exp));
		end
	endtask

	// Lowest valid row with this tag, -1 on a miss
	function automatic int model_find(input logic [PC_BITS-1:0] pc);
		for (int i = 0; i < BTB_ROWS; i++) begin
			if (m_valid[i] && m_tag[i] == pc[TAG_BITS+1:2]) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic btb_predict_t model_predict(input logic [PC_BITS-1:0] pc,
		input logic busy);
		btb_predict_t p;
		int row;
		row = model_find(pc);
		p.valid_target = (row >= 0) && !busy;
		p.target_pc    = '0;
		if (row >= 0) begin
			p.target_pc = {pc[PC_BITS-1:TARGET_BITS+2], m_target[row], 2'b00};
		end
		return p;
	endfunction

	task automatic model_resolve(input logic taken, input logic [PC_BITS-1:0] pc,
		input logic [PC_BITS-1:0] target);
		int row;
		row = model_find(pc);
		if (taken && row >= 0) begin
			m_target[row] = target[TARGET_BITS+1:2];    // Rewrite in place
		end else if (taken) begin
			m_valid[m_victim]  = 1'b1;
			m_tag[m_victim]    = pc[TAG_BITS+1:2];
			m_target[m_victim] = target[TARGET_BITS+1:2];
			m_victim           = (m_victim + 1) % BTB_ROWS;
		end else if (row >= 0) begin
			m_valid[row] = 1'b0;                      // Not taken hit drops the row
		end
	endtask

	// Known PCs still sit in unswept rows, random PCs before any are known
	function automatic logic [PC_BITS-1:0] pick_sweep_pc(input int n);
		if (known.size() > 0) begin
			return known[n % known.size()];
		end
		return {$random(seed)} & 32'hffff_fffc;
	endfunction

	task automatic fetch_check(input logic [PC_BITS-1:0] pc);
		@(negedge clock);
		fetch.pc = pc;
		resolve  = '0;
		flush    = 1'b0;
		#1;
		check_ready(ready, 1'b1);
		check_predict(predict, model_predict(pc, 1'b0));
	endtask

	task automatic send_resolve(input logic taken, input logic [PC_BITS-1:0] pc,
		input logic [PC_BITS-1:0] target);
		@(negedge clock);
		resolve.valid  = 1'b1;
		resolve.taken  = taken;
		resolve.pc     = pc;
		resolve.target = target;
		#1;
		check_ready(ready, 1'b1);
		model_resolve(taken, pc, target);
		known.push_back(pc);
	endtask

	task automatic check_all_known();
		foreach (known[i]) begin
			fetch_check(known[i]);
		end
	endtask

	// Counts the ready low cycles of a sweep while every fetch misses
	task automatic count_sweep();
		int cycles;
		cycles = 0;
		while (!ready) begin
			check_predict(predict, model_predict(fetch.pc, 1'b1));
			cycles++;
			if (cycles > 4 * BTB_ROWS) begin
				stop_run("timeout waiting for ready after sweep");
			end
			@(negedge clock);
			if (cycles < BTB_ROWS) begin
				fetch.pc       = pick_sweep_pc(cycles);
				resolve.valid  = 1'b1;                // Must be dropped while sweeping
				resolve.taken  = 1'b1;
				resolve.pc     = fetch.pc;
				resolve.target = {$random(seed)};
			end else begin
				resolve = '0;                         // Ready may rise, fetch held
			end
			#1;
		end
		if (cycles != BTB_ROWS) begin
			stop_run($sformatf("sweep lasted %0d cycles instead of %0d", cycles, BTB_ROWS));
		end
		for (int i = 0; i < BTB_ROWS; i++) begin
			m_valid[i] = 1'b0;
		end
		check_predict(predict, model_predict(fetch.pc, 1'b0)); // Last sweep resolve left no row
	endtask

	task automatic test_reset_sweep();
		int guard;
		guard = 0;
		do begin
			@(negedge clock);
			#1;
			guard++;
			if (guard > 20) begin
				stop_run("timeout waiting for reset release");
			end
		end while (reset);
		check_ready(ready, 1'b0);
		count_sweep();
	endtask

	task automatic test_insert();
		send_resolve(1'b1, 32'h0000_1104, 32'h0000_2468);
		fetch_check(32'h0000_1104);
		fetch_check(32'h0000_1108);               // Neighbour stays a miss
	endtask

	task automatic test_rewrite();
		send_resolve(1'b1, 32'h0000_1104, 32'h0000_3abc);
		fetch_check(32'h0000_1104);
		fetch_check(32'h5a5a_4104);               // Same tag, other upper bits
	endtask

	task automatic test_invalidate();
		send_resolve(1'b1, 32'h0000_0220, 32'h0000_0800);
		fetch_check(32'h0000_0220);
		send_resolve(1'b0, 32'h0000_0220, 32'h0000_0800);
		fetch_check(32'h0000_0220);
		send_resolve(1'b0, 32'h0000_0330, 32'h0000_0900);  // Miss, no change
		check_all_known();
	endtask

	task automatic test_replace();
		logic [PC_BITS-1:0] pcs [$];
		logic [PC_BITS-1:0] pc;
		logic               fresh;
		while (pcs.size() < BTB_ROWS + 1) begin
			pc    = {$random(seed)} & 32'hffff_fffc;
			fresh = (model_find(pc) < 0);
			foreach (pcs[i]) begin
				if (pcs[i][TAG_BITS+1:2] == pc[TAG_BITS+1:2]) begin
					fresh = 1'b0;
				end
			end
			if (fresh) begin
				pcs.push_back(pc);
				send_resolve(1'b1, pc, {$random(seed)});
			end
		end
		if (model_find(pcs[0]) >= 0) begin
			stop_run("first insert was not evicted in the reference model");
		end
		check_all_known();
	endtask

	task automatic test_flush();
		@(negedge clock);
		resolve = '0;
		flush   = 1'b1;
		#1;
		check_ready(ready, 1'b1);
		@(negedge clock);
		flush = 1'b0;
		#1;
		check_ready(ready, 1'b0);
		count_sweep();
		check_all_known();
		send_resolve(1'b1, 32'h0000_0abc, 32'h0000_1ff0);  // Lands at the kept victim row
		fetch_check(32'h0000_0abc);
		check_all_known();
	endtask

	initial begin
		fetch    = '0;
		resolve  = '0;
		flush    = 1'b0;
		m_victim = 0;
		for (int i = 0; i < BTB_ROWS; i++) begin
			m_valid[i]  = 1'b0;
			m_tag[i]    = '0;
			m_target[i] = '0;
		end
		test_reset_sweep();
		test_insert();
		test_rewrite();
		test_invalidate();
		test_replace();
		test_flush();
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#200000;
		$display("overall simulation timeout");
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== btb.f ====
verilog/btb_config_pkg.sv
verilog/btb_types_pkg.sv
verilog/btb_row_counter.sv
verilog/btb_sweep_fsm.sv
verilog/btb_tag_match.sv
verilog/btb_storage.sv
verilog/btb_top.sv
tests/btb_clock_gen.sv
tests/btb_assertions.sv
tests/btb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the BTB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module btb_tb -f btb.f \
	--Mdir obj_dir -o btb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/btb_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
echo "Pass message not found"
exit 1
